/* Makefile */
TOP := tb_mem_axi

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		--top-module $(TOP) -f src.f -o V$(TOP)

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+10)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* sim/mem_axi_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_axi_asserts (
    input logic                   clk,
    input logic                   reset,
    input logic                   mem_rsp_valid,
    input mem_req_pkg::mem_data_t mem_rsp_data,
    input mem_req_pkg::mem_tag_t  mem_rsp_tag,
    input logic                   mem_rsp_ready,
    input logic                   axi_error
);

    int unsigned violations;

    initial violations = 0;

    // Offered response stays put until the core takes it
    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && !mem_rsp_ready |=>
            mem_rsp_valid && $stable(mem_rsp_data) && $stable(mem_rsp_tag))
    else begin
        violations++;
        $error("mem_rsp_valid dropped or its payload changed before the handshake");
    end

    error_sticky: assert property (@(posedge clk) disable iff (reset)
        axi_error |=> axi_error)
    else begin
        violations++;
        $error("axi_error fell outside reset");
    end

    // First cycle out of reset
    reset_clean: assert property (@(posedge clk)
        $fell(reset) |-> !mem_rsp_valid && !axi_error)
    else begin
        violations++;
        $error("mem_rsp_valid or axi_error high right after reset");
    end

endmodule

`default_nettype wire

/* sim/tb_mem_axi.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_axi_consts.svh"

module tb_mem_axi;
    import mem_req_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int WORDS          = 2 ** `MEM_DEPTH_LOG2;
    localparam int PARTIAL_ROUNDS = 24;
    localparam int RANDOM_REQS    = 200;
    localparam int NUM_REQS       = WORDS + 2 + 2 * PARTIAL_ROUNDS + RANDOM_REQS + 3;
    localparam int LIMIT_CYCLES   = NUM_REQS * 20 + 100;

    logic           clk;
    logic           reset;
    logic           mem_req_valid;
    logic           mem_req_rw;
    mem_byteen_t    mem_req_byteen;
    mem_word_addr_t mem_req_addr;
    mem_data_t      mem_req_data;
    mem_tag_t       mem_req_tag;
    logic           mem_req_ready;
    logic           mem_rsp_valid;
    mem_data_t      mem_rsp_data;
    mem_tag_t       mem_rsp_tag;
    logic           mem_rsp_ready;
    logic           axi_error;

    integer    seed = 67;
    logic      stall_on;
    int        low_left;
    mem_data_t ref_mem [0:WORDS-1];
    mem_data_t exp_data_q [$];
    mem_tag_t  exp_tag_q [$];

    mem_axi_top DUT (.*);

    bind mem_axi_top mem_axi_asserts protocol_checks (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .axi_error     (axi_error)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped on the first failure");
    endtask

    task automatic fail_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        $display("ERROR: time %0t signal %s expected %h actual %h",
                 $time, name, expected, actual);
        abort_run();
    endtask

    function automatic logic in_range(input mem_word_addr_t addr);
        return (addr >> `MEM_DEPTH_LOG2) == 0;
    endfunction

    // Every address bit shows up in the word
    function automatic mem_data_t fill_word(input int a);
        return {8{a[7:0]}} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic mem_data_t merge_bytes(input mem_data_t old_word,
                                              input mem_data_t new_word,
                                              input mem_byteen_t be);
        mem_data_t result;
        result = old_word;
        for (int i = 0; i < $bits(mem_byteen_t); i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // Entered and left on a falling edge
    task automatic send_req(input logic rw, input mem_word_addr_t addr, input mem_data_t data,
                            input mem_byteen_t be, input mem_tag_t tag);
        logic accepted;
        accepted       = 1'b0;
        mem_req_valid  = 1'b1;
        mem_req_rw     = rw;
        mem_req_addr   = addr;
        mem_req_data   = data;
        mem_req_byteen = be;
        mem_req_tag    = tag;
        while (!accepted) begin
            #1;
            accepted = mem_req_ready;
            @(negedge clk);
        end
        mem_req_valid = 1'b0;
        if (rw) begin
            if (in_range(addr)) begin
                ref_mem[addr[`MEM_DEPTH_LOG2-1:0]] =
                    merge_bytes(ref_mem[addr[`MEM_DEPTH_LOG2-1:0]], data, be);
            end
        end else begin
            exp_data_q.push_back(in_range(addr) ? ref_mem[addr[`MEM_DEPTH_LOG2-1:0]] : '0);
            exp_tag_q.push_back(tag);
        end
    endtask

    task automatic check_response();
        mem_data_t exp_data;
        mem_tag_t  exp_tag;
        if (exp_data_q.size() == 0) begin
            $display("A response came out at time %0t with no read outstanding", $time);
            abort_run();
        end
        exp_data = exp_data_q.pop_front();
        exp_tag  = exp_tag_q.pop_front();
        assert (mem_rsp_tag === exp_tag)
            else fail_value("mem_rsp_tag", 64'(exp_tag), 64'(mem_rsp_tag));
        assert (mem_rsp_data === exp_data)
            else fail_value("mem_rsp_data", exp_data, mem_rsp_data);
    endtask

    task automatic drain_responses();
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic wait_error_flag();
        int waited;
        waited = 0;
        while (axi_error !== 1'b1) begin
            if (waited == 10) begin
                $display("axi_error did not rise after an out-of-range write");
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // Drive the response ready pattern and check each taken response
    always begin
        @(negedge clk);
        if (!stall_on) begin
            mem_rsp_ready = 1'b1;
        end else if (low_left > 0) begin
            low_left--;
            mem_rsp_ready = 1'b0;
        end else if (($random(seed) & 3) == 0) begin
            low_left      = $random(seed) & 7;
            mem_rsp_ready = 1'b0;
        end else begin
            mem_rsp_ready = 1'b1;
        end
        #1;
        if (DUT.protocol_checks.violations != 0) begin
            $display("A bound protocol assertion failed before time %0t", $time);
            abort_run();
        end
        if (mem_rsp_valid === 1'b1 && mem_rsp_ready) begin
            check_response();
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        abort_run();
    end

    initial begin
        mem_word_addr_t addr;
        mem_data_t      data;
        reset          = 1'b1;
        mem_req_valid  = 1'b0;
        mem_req_rw     = 1'b0;
        mem_req_byteen = '0;
        mem_req_addr   = '0;
        mem_req_data   = '0;
        mem_req_tag    = '0;
        mem_rsp_ready  = 1'b1;
        stall_on       = 1'b0;
        low_left       = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (mem_rsp_valid === 1'b0) else fail_value("mem_rsp_valid", 0, mem_rsp_valid);
        assert (axi_error === 1'b0) else fail_value("axi_error", 0, axi_error);

        // Known contents in every word before any read
        for (int a = 0; a < WORDS; a++) begin
            send_req(1'b1, mem_word_addr_t'(a), fill_word(a), '1, mem_tag_t'(a));
        end

        data = {$random(seed), $random(seed)};
        send_req(1'b1, 13'd5, data, '1, 4'h3);
        send_req(1'b0, 13'd5, '0, '0, 4'ha);
        drain_responses();

        repeat (PARTIAL_ROUNDS) begin
            addr = mem_word_addr_t'($random(seed) & 8'hff);
            send_req(1'b1, addr, {$random(seed), $random(seed)},
                     mem_byteen_t'($random(seed)), mem_tag_t'($random(seed)));
            send_req(1'b0, addr, '0, '0, mem_tag_t'($random(seed)));
        end
        drain_responses();

        // Small address window so reads hit recent writes
        stall_on = 1'b1;
        repeat (RANDOM_REQS) begin
            send_req(1'($random(seed)), mem_word_addr_t'($random(seed) & 15),
                     {$random(seed), $random(seed)}, mem_byteen_t'($random(seed)),
                     mem_tag_t'($random(seed)));
            if (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end
        end
        stall_on = 1'b0;
        drain_responses();
        assert (axi_error === 1'b0) else fail_value("axi_error", 0, axi_error);

        // Out-of-range write aliases word 0x2a in the low index bits
        addr = 13'h02a;
        send_req(1'b1, addr | 13'h100, {$random(seed), $random(seed)}, '1, 4'h6);
        wait_error_flag();
        send_req(1'b0, addr, '0, '0, 4'h7);
        send_req(1'b0, '1, '0, '0, 4'h8);
        drain_responses();
        assert (axi_error === 1'b1) else fail_value("axi_error", 1, axi_error);

        if (DUT.protocol_checks.violations == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("A bound protocol assertion failed during the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/mem_req_pkg.sv
src/axi_pkg.sv
src/axi_if.sv
src/mem_ifs.sv
src/mem_axi_adapter.sv
src/axi_ram_ctrl.sv
src/axi_ram_array.sv
src/rsp_skid_buffer.sv
src/mem_axi_top.sv
sim/mem_axi_asserts.sv
sim/tb_mem_axi.sv

/* src/axi_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface axi_if;

    // Write address
    logic                     awvalid;
    logic                     awready;
    axi_pkg::axi_addr_t       awaddr;
    axi_pkg::axi_id_t         awid;
    axi_pkg::axi_size_t       awsize;

    // Write data
    logic                     wvalid;
    logic                     wready;
    mem_req_pkg::mem_data_t   wdata;
    mem_req_pkg::mem_byteen_t wstrb;
    logic                     wlast;

    // Write response
    logic                     bvalid;
    logic                     bready;
    axi_pkg::axi_id_t         bid;
    axi_pkg::axi_resp_e       bresp;

    // Read address
    logic                     arvalid;
    logic                     arready;
    axi_pkg::axi_addr_t       araddr;
    axi_pkg::axi_id_t         arid;
    axi_pkg::axi_size_t       arsize;

    // Read data
    logic                     rvalid;
    logic                     rready;
    mem_req_pkg::mem_data_t   rdata;
    axi_pkg::axi_id_t         rid;
    axi_pkg::axi_resp_e       rresp;
    logic                     rlast;

    modport master (
        output awvalid, awaddr, awid, awsize,
        input  awready,
        output wvalid, wdata, wstrb, wlast,
        input  wready,
        input  bvalid, bid, bresp,
        output bready,
        output arvalid, araddr, arid, arsize,
        input  arready,
        input  rvalid, rdata, rid, rresp, rlast,
        output rready
    );

    modport slave (
        input  awvalid, awaddr, awid, awsize,
        output awready,
        input  wvalid, wdata, wstrb, wlast,
        output wready,
        output bvalid, bid, bresp,
        input  bready,
        input  arvalid, araddr, arid, arsize,
        output arready,
        output rvalid, rdata, rid, rresp, rlast,
        input  rready
    );

endinterface

`default_nettype wire

/* src/axi_pkg.sv */
`default_nettype none

`include "mem_axi_consts.svh"

package axi_pkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0] axi_addr_t;

    typedef logic [`MEM_TAG_WIDTH-1:0] axi_id_t;

    // Beat size code as log2 of bytes per beat
    typedef logic [2:0] axi_size_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_WDATA,
        RAM_BRESP,
        RAM_RDATA
    } ram_state_e;

endpackage

`default_nettype wire

/* src/axi_ram_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_axi_consts.svh"

module axi_ram_array (
    input  logic      clk,
    ram_port_if.array ram
);
    import mem_req_pkg::*;

    localparam int WORDS = 2 ** `MEM_DEPTH_LOG2;
    localparam int BYTES = `MEM_DATA_WIDTH / 8;

    mem_data_t mem [0:WORDS-1];
    mem_data_t rdata_q;

    // Byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (ram.en) begin
            if (ram.we) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (ram.strb[b]) begin
                        mem[ram.idx][b*8 +: 8] <= ram.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[ram.idx];
            end
        end
    end

    // Holds the last read word until the next read
    assign ram.rdata = rdata_q;

endmodule

`default_nettype wire

/* src/axi_ram_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_axi_consts.svh"

module axi_ram_ctrl (
    input  logic    clk,
    input  logic    reset,
    axi_if.slave    axi,
    ram_port_if.ctrl ram
);
    import axi_pkg::*;

    localparam int WORD_SIZE = $clog2(`MEM_DATA_WIDTH / 8);
    localparam int IDX_LSB   = WORD_SIZE;
    localparam int IDX_MSB   = `MEM_DEPTH_LOG2 + WORD_SIZE - 1;

    ram_state_e                 state;
    axi_id_t                    id_q;
    logic [`MEM_DEPTH_LOG2-1:0] idx_q;
    logic                       err_q;
    logic                       ar_fire;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       ar_bad;
    axi_resp_e                  resp;

    // Word index past the RAM depth, or a beat size other than one full word
    function automatic logic addr_bad(input axi_addr_t addr, input axi_size_t size);
        return (|addr[`MEM_ADDR_WIDTH-1:IDX_MSB+1]) || (size != axi_size_t'(WORD_SIZE));
    endfunction

    assign ar_fire = axi.arvalid && axi.arready;
    assign aw_fire = axi.awvalid && axi.awready;
    assign w_fire  = axi.wvalid && axi.wready;
    assign ar_bad  = addr_bad(axi.araddr, axi.arsize);

    // Reads win over writes when both arrive in idle
    assign axi.arready = (state == RAM_IDLE);
    assign axi.awready = (state == RAM_IDLE) && !axi.arvalid;
    assign axi.wready  = (state == RAM_WDATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RAM_IDLE;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (ar_fire) begin
                        state <= RAM_RDATA;
                    end else if (aw_fire) begin
                        state <= RAM_WDATA;
                    end
                end
                RAM_WDATA: if (w_fire) state <= RAM_BRESP;
                RAM_BRESP: if (axi.bready) state <= RAM_IDLE;
                RAM_RDATA: if (axi.rready) state <= RAM_IDLE;
                default:   state <= RAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RAM_IDLE && ar_fire) begin
            id_q  <= axi.arid;
            err_q <= ar_bad;
        end else if (state == RAM_IDLE && aw_fire) begin
            id_q  <= axi.awid;
            idx_q <= axi.awaddr[IDX_MSB:IDX_LSB];
            err_q <= addr_bad(axi.awaddr, axi.awsize);
        end else if (w_fire && !axi.wlast) begin
            // Only single-beat writes are supported
            err_q <= 1'b1;
        end
    end

    // Read is launched on AR acceptance so data is ready in RAM_RDATA
    assign ram.en    = (ar_fire && !ar_bad) || (w_fire && axi.wlast && !err_q);
    assign ram.we    = (state == RAM_WDATA);
    assign ram.idx   = (state == RAM_IDLE) ? axi.araddr[IDX_MSB:IDX_LSB] : idx_q;
    assign ram.strb  = axi.wstrb;
    assign ram.wdata = axi.wdata;

    assign resp      = err_q ? SLVERR : OKAY;

    assign axi.bvalid = (state == RAM_BRESP);
    assign axi.bid    = id_q;
    assign axi.bresp  = resp;

    assign axi.rvalid = (state == RAM_RDATA);
    assign axi.rdata  = err_q ? '0 : ram.rdata;
    assign axi.rid    = id_q;
    assign axi.rresp  = resp;
    assign axi.rlast  = 1'b1;

endmodule

`default_nettype wire

/* src/mem_axi_adapter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_axi_consts.svh"

module mem_axi_adapter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_req_valid,
    input  logic                        mem_req_rw,
    input  mem_req_pkg::mem_byteen_t    mem_req_byteen,
    input  mem_req_pkg::mem_word_addr_t mem_req_addr,
    input  mem_req_pkg::mem_data_t      mem_req_data,
    input  mem_req_pkg::mem_tag_t       mem_req_tag,
    output logic                        mem_req_ready,
    axi_if.master                       axi,
    mem_rsp_if.source                   rsp,
    output logic                        axi_error
);
    import axi_pkg::*;

    localparam int AXI_SIZE = $clog2(`MEM_DATA_WIDTH / 8);

    logic aw_ack;
    logic w_ack;
    logic write_ready;
    logic req_fire;
    logic b_fire;
    logic r_fire;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign b_fire   = axi.bvalid && axi.bready;
    assign r_fire   = axi.rvalid && axi.rready;

    // Remember which write channels already completed for the current request
    always_ff @(posedge clk) begin
        if (reset || req_fire) begin
            aw_ack <= 1'b0;
            w_ack  <= 1'b0;
        end else begin
            aw_ack <= aw_ack || (axi.awvalid && axi.awready);
            w_ack  <= w_ack || (axi.wvalid && axi.wready);
        end
    end

    assign axi.awvalid = mem_req_valid && mem_req_rw && !aw_ack;
    assign axi.awaddr  = axi_addr_t'(mem_req_addr) << AXI_SIZE;
    assign axi.awid    = mem_req_tag;
    assign axi.awsize  = axi_size_t'(AXI_SIZE);

    assign axi.wvalid  = mem_req_valid && mem_req_rw && !w_ack;
    assign axi.wdata   = mem_req_data;
    assign axi.wstrb   = mem_req_byteen;
    assign axi.wlast   = 1'b1;

    // Write responses are never stalled
    assign axi.bready  = 1'b1;

    assign axi.arvalid = mem_req_valid && !mem_req_rw;
    assign axi.araddr  = axi_addr_t'(mem_req_addr) << AXI_SIZE;
    assign axi.arid    = mem_req_tag;
    assign axi.arsize  = axi_size_t'(AXI_SIZE);

    assign rsp.valid   = axi.rvalid;
    assign rsp.data    = axi.rdata;
    assign rsp.tag     = axi.rid;
    assign axi.rready  = rsp.ready;

    assign write_ready   = (axi.awready || aw_ack) && (axi.wready || w_ack);
    assign mem_req_ready = mem_req_rw ? write_ready : axi.arready;

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            axi_error <= 1'b0;
        end else if ((b_fire && axi.bresp != OKAY) ||
                     (r_fire && (axi.rresp != OKAY || !axi.rlast))) begin
            axi_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/mem_axi_consts.svh */
`ifndef MEM_AXI_CONSTS_SVH
`define MEM_AXI_CONSTS_SVH

// Core word and AXI bus widths
`define MEM_DATA_WIDTH 64
`define MEM_ADDR_WIDTH 16

// Tag doubles as the AXI transaction ID
`define MEM_TAG_WIDTH 4

// 256 words of on-chip storage
`define MEM_DEPTH_LOG2 8

`endif

/* src/mem_axi_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_axi_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_req_valid,
    input  logic                        mem_req_rw,
    input  mem_req_pkg::mem_byteen_t    mem_req_byteen,
    input  mem_req_pkg::mem_word_addr_t mem_req_addr,
    input  mem_req_pkg::mem_data_t      mem_req_data,
    input  mem_req_pkg::mem_tag_t       mem_req_tag,
    output logic                        mem_req_ready,
    output logic                        mem_rsp_valid,
    output mem_req_pkg::mem_data_t      mem_rsp_data,
    output mem_req_pkg::mem_tag_t       mem_rsp_tag,
    input  logic                        mem_rsp_ready,
    output logic                        axi_error
);

    axi_if      axi_bus ();
    ram_port_if ram_port ();
    mem_rsp_if  rsp_bus ();

    mem_axi_adapter adapter (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .axi            (axi_bus.master),
        .rsp            (rsp_bus.source),
        .axi_error      (axi_error)
    );

    axi_ram_ctrl ram_ctrl (
        .clk   (clk),
        .reset (reset),
        .axi   (axi_bus.slave),
        .ram   (ram_port.ctrl)
    );

    axi_ram_array ram_array (
        .clk (clk),
        .ram (ram_port.array)
    );

    rsp_skid_buffer rsp_buf (
        .clk           (clk),
        .reset         (reset),
        .rsp           (rsp_bus.sink),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready)
    );

endmodule

`default_nettype wire

/* src/mem_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_axi_consts.svh"

// Storage port between the AXI target controller and the word array
interface ram_port_if;

    logic                       en;
    logic                       we;
    logic [`MEM_DEPTH_LOG2-1:0] idx;
    mem_req_pkg::mem_byteen_t   strb;
    mem_req_pkg::mem_data_t     wdata;
    mem_req_pkg::mem_data_t     rdata;

    modport ctrl (
        output en, we, idx, strb, wdata,
        input  rdata
    );

    modport array (
        input  en, we, idx, strb, wdata,
        output rdata
    );

endinterface

// Read responses from the bridge into the skid buffer
interface mem_rsp_if;

    logic                   valid;
    logic                   ready;
    mem_req_pkg::mem_data_t data;
    mem_req_pkg::mem_tag_t  tag;

    modport source (output valid, data, tag, input ready);

    modport sink (input valid, data, tag, output ready);

endinterface

`default_nettype wire

/* src/mem_req_pkg.sv */
`default_nettype none

`include "mem_axi_consts.svh"

package mem_req_pkg;

    typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

    typedef logic [`MEM_DATA_WIDTH/8-1:0] mem_byteen_t;

    // Word address with the byte offset bits stripped
    typedef logic [`MEM_ADDR_WIDTH-4:0] mem_word_addr_t;

    typedef logic [`MEM_TAG_WIDTH-1:0] mem_tag_t;

endpackage

`default_nettype wire

/* src/rsp_skid_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module rsp_skid_buffer (
    input  logic                   clk,
    input  logic                   reset,
    mem_rsp_if.sink                rsp,
    output logic                   mem_rsp_valid,
    output mem_req_pkg::mem_data_t mem_rsp_data,
    output mem_req_pkg::mem_tag_t  mem_rsp_tag,
    input  logic                   mem_rsp_ready
);
    import mem_req_pkg::*;

    logic      skid_valid;
    mem_data_t skid_data;
    mem_tag_t  skid_tag;
    logic      push;
    logic      pop;
    logic      out_free;

    assign rsp.ready = !(mem_rsp_valid && skid_valid);
    assign push      = rsp.valid && rsp.ready;
    assign pop       = mem_rsp_valid && mem_rsp_ready;
    assign out_free  = !mem_rsp_valid || pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rsp_valid <= 1'b0;
            skid_valid    <= 1'b0;
        end else if (out_free) begin
            mem_rsp_valid <= skid_valid || push;
            skid_valid    <= 1'b0;
        end else if (push) begin
            skid_valid    <= 1'b1;
        end
    end

    // Older entry moves to the output first
    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                mem_rsp_data <= skid_data;
                mem_rsp_tag  <= skid_tag;
            end else if (push) begin
                mem_rsp_data <= rsp.data;
                mem_rsp_tag  <= rsp.tag;
            end
        end
        if (push && !out_free) begin
            skid_data <= rsp.data;
            skid_tag  <= rsp.tag;
        end
    end

endmodule

`default_nettype wire
